// ==== design/icmp_pkg.sv ====
// icmp_pkg: widths, queue depths and packed structs for the ICMP checksum generator

`default_nettype none

package icmp_pkg;

    // payload beat geometry
    localparam int data_bytes = 8;
    localparam int data_w = 64;

    // queue depths
    localparam int payload_fifo_depth = 16;
    localparam int meta_fifo_depth = 4;

    // 16-bit add plus its carry
    typedef logic [16:0] csum_part_t;

    // payload length in bytes
    typedef logic [15:0] byte_cnt_t;

    // icmp header without the checksum field
    typedef struct packed {
        logic [7:0]  icmp_type;
        logic [7:0]  code;
        logic [31:0] rest;
    } icmp_hdr_t;

    // one payload beat with lane 0 in the low byte
    typedef struct packed {
        logic [data_w-1:0]     data;
        logic [data_bytes-1:0] keep;
        logic                  last;
    } payload_beat_t;

    // result released downstream per frame
    typedef struct packed {
        icmp_hdr_t   hdr;
        logic [15:0] checksum;
        byte_cnt_t   length;
    } icmp_meta_t;

endpackage

`default_nettype wire

// ==== design/sync_fifo.sv ====
// sync_fifo: synchronous valid/ready queue with element type and depth parameters

`default_nettype none

module sync_fifo #(
    parameter type elem_t = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  elem_t in_data,
    input  logic  in_valid,
    output logic  in_ready,
    output elem_t out_data,
    output logic  out_valid,
    input  logic  out_ready
);

    elem_t mem [DEPTH];

    // one extra bit tells full from empty
    logic [$clog2(DEPTH):0] wr_ptr;
    logic [$clog2(DEPTH):0] rd_ptr;
    logic                   full;
    logic                   empty;
    logic                   write;
    logic                   load;

    assign full = (wr_ptr[$clog2(DEPTH)] != rd_ptr[$clog2(DEPTH)]) &&
                  (wr_ptr[$clog2(DEPTH)-1:0] == rd_ptr[$clog2(DEPTH)-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign in_ready = !full;
    assign write = in_valid && !full;

    // refill the output stage when it is empty or being taken
    assign load = !empty && (!out_valid || out_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            out_valid <= 1'b0;
        end else begin
            if (write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load) begin
                rd_ptr <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr[$clog2(DEPTH)-1:0]] <= in_data;
        end
        if (load) begin
            out_data <= mem[rd_ptr[$clog2(DEPTH)-1:0]];
        end
    end

    // a stalled output keeps its word
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// ==== design/icmp_beat_sum.sv ====
// icmp_beat_sum: folds the kept bytes of one payload beat into two partial sums and a byte count

`default_nettype none

module icmp_beat_sum (
    input  logic                    clk,
    input  logic                    rst,
    input  icmp_pkg::payload_beat_t beat,
    input  logic                    beat_valid,
    output icmp_pkg::csum_part_t    sum_lo,
    output icmp_pkg::csum_part_t    sum_hi,
    output icmp_pkg::byte_cnt_t     byte_count
);
    import icmp_pkg::*;

    logic [7:0] lane [data_bytes];

    // dropped lanes read as zero, which also pads a trailing odd byte
    always_comb begin
        for (int i = 0; i < data_bytes; i++) begin
            lane[i] = beat.keep[i] ? beat.data[8*i +: 8] : 8'h00;
        end
    end

    // even lane is the high byte of each big-endian word
    assign sum_lo = {1'b0, lane[0], lane[1]} + {1'b0, lane[2], lane[3]};
    assign sum_hi = {1'b0, lane[4], lane[5]} + {1'b0, lane[6], lane[7]};

    // keep is contiguous, so counting ones gives the length
    always_comb begin
        byte_count = '0;
        for (int i = 0; i < data_bytes; i++) begin
            byte_count = byte_count + byte_cnt_t'(beat.keep[i]);
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        beat_valid |-> (beat.keep != '0) && ((beat.keep & (beat.keep + 1'b1)) == '0));

endmodule

`default_nettype wire

// ==== design/icmp_csum_ctrl.sv ====
// icmp_csum_ctrl: header capture, payload gating, pipelined checksum accumulation and result push

`default_nettype none

module icmp_csum_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  icmp_pkg::icmp_hdr_t  s_hdr,
    input  logic                 s_hdr_valid,
    output logic                 s_hdr_ready,
    input  logic                 s_payload_valid,
    input  logic                 s_payload_last,
    output logic                 s_payload_ready,
    output logic                 payload_push,
    input  logic                 payload_q_ready,
    input  icmp_pkg::csum_part_t beat_lo,
    input  icmp_pkg::csum_part_t beat_hi,
    input  icmp_pkg::byte_cnt_t  beat_bytes,
    output icmp_pkg::icmp_meta_t meta,
    output logic                 meta_push,
    input  logic                 meta_q_ready,
    output logic                 busy
);
    import icmp_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_sum_hdr,
        st_sum_payload,
        st_finish_1,
        st_finish_2
    } state_t;

    state_t      state;
    state_t      state_next;
    logic        hdr_xfer;
    logic        s_hdr_ready_next;
    logic        meta_push_next;

    icmp_hdr_t   hdr_reg;
    logic [31:0] acc;
    csum_part_t  part_lo;
    csum_part_t  part_hi;
    byte_cnt_t   byte_cnt;
    logic [16:0] fold_1;
    logic [15:0] fold_2;

    assign hdr_xfer = s_hdr_valid && s_hdr_ready;

    // payload only flows while summing and the queue has room
    assign s_payload_ready = (state == st_sum_payload) && payload_q_ready;
    assign payload_push = s_payload_valid && s_payload_ready;

    // still busy in the cycle the result goes into the queue
    assign busy = (state != st_idle) || meta_push;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (hdr_xfer) begin
                    state_next = st_sum_hdr;
                end
            end
            st_sum_hdr: begin
                state_next = st_sum_payload;
            end
            st_sum_payload: begin
                if (payload_push && s_payload_last) begin
                    state_next = st_finish_1;
                end
            end
            st_finish_1: begin
                state_next = st_finish_2;
            end
            st_finish_2: begin
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    assign meta_push_next = (state == st_finish_2);

    // hold off the next header until the previous push has landed in the queue
    assign s_hdr_ready_next = (state_next == st_idle) && !meta_push_next && !meta_push &&
                              meta_q_ready;

    // end-around carry folded back twice into 16 bits
    assign fold_1 = {1'b0, acc[15:0]} + {1'b0, acc[31:16]};
    assign fold_2 = fold_1[15:0] + {15'd0, fold_1[16]};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            s_hdr_ready <= 1'b0;
            meta_push <= 1'b0;
        end else begin
            state <= state_next;
            s_hdr_ready <= s_hdr_ready_next;
            meta_push <= meta_push_next;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            hdr_reg <= s_hdr;
        end

        case (state)
            st_sum_hdr: begin
                // type and code as one word, then both halves of rest
                acc <= '0;
                part_lo <= {1'b0, hdr_reg.icmp_type, hdr_reg.code} + {1'b0, hdr_reg.rest[31:16]};
                part_hi <= {1'b0, hdr_reg.rest[15:0]};
                byte_cnt <= '0;
            end
            st_sum_payload: begin
                if (payload_push) begin
                    // partials of the previous beat go in one cycle late
                    acc <= acc + part_lo + part_hi;
                    part_lo <= beat_lo;
                    part_hi <= beat_hi;
                    byte_cnt <= byte_cnt + beat_bytes;
                end
            end
            st_finish_1: begin
                // drain the last beat's partials
                acc <= acc + part_lo + part_hi;
            end
            st_finish_2: begin
                meta.hdr <= hdr_reg;
                meta.checksum <= ~fold_2;
                meta.length <= byte_cnt;
            end
            default: begin
            end
        endcase
    end

    // a frame is only accepted when the result queue has a slot for it
    assert property (@(posedge clk) disable iff (rst) meta_push |-> meta_q_ready);

    // an offered beat stays offered until it is taken
    assert property (@(posedge clk) disable iff (rst)
        s_payload_valid && !s_payload_ready |=> s_payload_valid);

endmodule

`default_nettype wire

// ==== design/icmp_checksum_gen.sv ====
// icmp_checksum_gen: top level with controller, beat folder, payload queue and result queue

`default_nettype none

module icmp_checksum_gen (
    input  logic                    clk,
    input  logic                    rst,
    input  icmp_pkg::icmp_hdr_t     s_hdr,
    input  logic                    s_hdr_valid,
    output logic                    s_hdr_ready,
    input  icmp_pkg::payload_beat_t s_payload,
    input  logic                    s_payload_valid,
    output logic                    s_payload_ready,
    output icmp_pkg::icmp_meta_t    m_meta,
    output logic                    m_meta_valid,
    input  logic                    m_meta_ready,
    output icmp_pkg::payload_beat_t m_payload,
    output logic                    m_payload_valid,
    input  logic                    m_payload_ready,
    output logic                    busy
);
    import icmp_pkg::*;

    logic       payload_push;
    logic       payload_q_ready;
    csum_part_t beat_lo;
    csum_part_t beat_hi;
    byte_cnt_t  beat_bytes;
    icmp_meta_t meta;
    logic       meta_push;
    logic       meta_q_ready;

    icmp_csum_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .s_hdr          (s_hdr),
        .s_hdr_valid    (s_hdr_valid),
        .s_hdr_ready    (s_hdr_ready),
        .s_payload_valid(s_payload_valid),
        .s_payload_last (s_payload.last),
        .s_payload_ready(s_payload_ready),
        .payload_push   (payload_push),
        .payload_q_ready(payload_q_ready),
        .beat_lo        (beat_lo),
        .beat_hi        (beat_hi),
        .beat_bytes     (beat_bytes),
        .meta           (meta),
        .meta_push      (meta_push),
        .meta_q_ready   (meta_q_ready),
        .busy           (busy)
    );

    // combinational fold of the beat on the input bus
    icmp_beat_sum u_beat_sum (
        .clk       (clk),
        .rst       (rst),
        .beat      (s_payload),
        .beat_valid(payload_push),
        .sum_lo    (beat_lo),
        .sum_hi    (beat_hi),
        .byte_count(beat_bytes)
    );

    sync_fifo #(
        .elem_t(payload_beat_t),
        .DEPTH (payload_fifo_depth)
    ) u_payload_q (
        .clk      (clk),
        .rst      (rst),
        .in_data  (s_payload),
        .in_valid (payload_push),
        .in_ready (payload_q_ready),
        .out_data (m_payload),
        .out_valid(m_payload_valid),
        .out_ready(m_payload_ready)
    );

    sync_fifo #(
        .elem_t(icmp_meta_t),
        .DEPTH (meta_fifo_depth)
    ) u_meta_q (
        .clk      (clk),
        .rst      (rst),
        .in_data  (meta),
        .in_valid (meta_push),
        .in_ready (meta_q_ready),
        .out_data (m_meta),
        .out_valid(m_meta_valid),
        .out_ready(m_meta_ready)
    );

endmodule

`default_nettype wire

// ==== sim/tb_icmp_checks.svh ====
// reference checksum model and typed compare tasks for the ICMP checksum testbench

`ifndef TB_ICMP_CHECKS_SVH
`define TB_ICMP_CHECKS_SVH

// expected result for the header and the beats in tx_beats
function automatic icmp_meta_t ref_meta(input icmp_hdr_t hdr);
    icmp_meta_t    res;
    payload_beat_t beat;
    logic [7:0]    stream [0:data_bytes*32-1];
    logic [31:0]   sum;
    logic [15:0]   word;
    int            n;
    int            k;
    int            i;
    n = 0;
    for (k = 0; k < tx_beats.size(); k++) begin
        beat = tx_beats[k];
        for (i = 0; i < data_bytes; i++) begin
            if (beat.keep[i]) begin
                stream[n] = beat.data[8*i +: 8];
                n++;
            end
        end
    end
    sum = {16'd0, hdr.icmp_type, hdr.code} + {16'd0, hdr.rest[31:16]} +
          {16'd0, hdr.rest[15:0]};
    // byte stream as big-endian words with a zero-padded odd tail
    for (i = 0; i < n; i += 2) begin
        word = {stream[i], ((i + 1 < n) ? stream[i + 1] : 8'h00)};
        sum = sum + {16'd0, word};
    end
    while (sum[31:16] != 16'd0) begin
        sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    end
    res.hdr = hdr;
    res.checksum = ~sum[15:0];
    res.length = byte_cnt_t'(n);
    return res;
endfunction

task automatic check_meta(input icmp_meta_t got, input icmp_meta_t exp, input string what);
    if (got !== exp) begin
        $display("ERR %0t: %s type %h code %h rest %h csum %h len %0d, expected csum %h len %0d",
                 $time, what, got.hdr.icmp_type, got.hdr.code, got.hdr.rest, got.checksum,
                 got.length, exp.checksum, exp.length);
        err_value++;
    end
endtask

task automatic check_beat(input payload_beat_t got, input payload_beat_t exp, input string what);
    if (got !== exp) begin
        $display("ERR %0t: %s beat %h/%h/%b, expected %h/%h/%b", $time, what,
                 got.data, got.keep, got.last, exp.data, exp.keep, exp.last);
        err_value++;
    end
endtask

task automatic expect_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        err_value++;
    end
endtask

`endif

// ==== sim/tb_icmp_checksum_gen.sv ====
// tb_icmp_checksum_gen: clock, reset, DUT, output scoreboard and directed frame tests

`default_nettype none

module tb_icmp_checksum_gen;
    import icmp_pkg::*;

    localparam int wait_limit = 400;

    logic          clk;
    logic          rst;
    icmp_hdr_t     s_hdr;
    logic          s_hdr_valid;
    logic          s_hdr_ready;
    payload_beat_t s_payload;
    logic          s_payload_valid;
    logic          s_payload_ready;
    icmp_meta_t    m_meta;
    logic          m_meta_valid;
    logic          m_meta_ready;
    payload_beat_t m_payload;
    logic          m_payload_valid;
    logic          m_payload_ready;
    logic          busy;

    integer        seed;
    int            err_value;
    int            err_other;
    payload_beat_t tx_beats [$];
    payload_beat_t exp_beat_q [$];
    icmp_meta_t    exp_meta_q [$];

    `include "tb_icmp_checks.svh"

    icmp_checksum_gen u_dut (
        .clk            (clk),
        .rst            (rst),
        .s_hdr          (s_hdr),
        .s_hdr_valid    (s_hdr_valid),
        .s_hdr_ready    (s_hdr_ready),
        .s_payload      (s_payload),
        .s_payload_valid(s_payload_valid),
        .s_payload_ready(s_payload_ready),
        .m_meta         (m_meta),
        .m_meta_valid   (m_meta_valid),
        .m_meta_ready   (m_meta_ready),
        .m_payload      (m_payload),
        .m_payload_valid(m_payload_valid),
        .m_payload_ready(m_payload_ready),
        .busy           (busy)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // scoreboard on both output streams
    always @(posedge clk) begin
        if (!rst && m_payload_valid && m_payload_ready) begin
            if (exp_beat_q.size() == 0) begin
                $display("an unexpected payload beat came out at time %0t", $time);
                err_other++;
            end else begin
                check_beat(m_payload, exp_beat_q.pop_front(), "payload");
            end
        end
        if (!rst && m_meta_valid && m_meta_ready) begin
            if (exp_meta_q.size() == 0) begin
                $display("an unexpected result came out at time %0t", $time);
                err_other++;
            end else begin
                check_meta(m_meta, exp_meta_q.pop_front(), "result");
            end
        end
    end

    // random header and beats with last_bytes lanes kept in the final beat
    task automatic make_frame(input int nbeats, input int last_bytes, output icmp_hdr_t hdr);
        payload_beat_t beat;
        int            mask;
        int            k;
        hdr.icmp_type = $random(seed);
        hdr.code = $random(seed);
        hdr.rest = $random(seed);
        mask = (1 << last_bytes) - 1;
        tx_beats.delete();
        for (k = 0; k < nbeats; k++) begin
            beat.data = {$random(seed), $random(seed)};
            beat.keep = (k == nbeats - 1) ? mask[data_bytes-1:0] : '1;
            beat.last = (k == nbeats - 1);
            tx_beats.push_back(beat);
            exp_beat_q.push_back(beat);
        end
        exp_meta_q.push_back(ref_meta(hdr));
    endtask

    task automatic send_frame(input icmp_hdr_t hdr);
        int cycles;
        int k;
        @(posedge clk);
        s_hdr <= hdr;
        s_hdr_valid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!s_hdr_ready && cycles < wait_limit);
        s_hdr_valid <= 1'b0;
        if (!s_hdr_ready) begin
            $display("the header was not accepted in time at %0t", $time);
            err_other++;
            return;
        end
        for (k = 0; k < tx_beats.size(); k++) begin
            s_payload <= tx_beats[k];
            s_payload_valid <= 1'b1;
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
                // frame in flight from the header step to the last beat
                expect_flag(busy, 1'b1, "busy during a frame");
            end while (!s_payload_ready && cycles < wait_limit);
            if (!s_payload_ready) begin
                $display("payload beat %0d was not accepted in time at %0t", k, $time);
                err_other++;
                s_payload_valid <= 1'b0;
                return;
            end
        end
        s_payload_valid <= 1'b0;
    endtask

    task automatic wait_drained(input string what);
        int cycles;
        cycles = 0;
        while ((exp_beat_q.size() != 0 || exp_meta_q.size() != 0) && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_beat_q.size() != 0 || exp_meta_q.size() != 0) begin
            $display("%s did not come out in time, %0d beats and %0d results missing",
                     what, exp_beat_q.size(), exp_meta_q.size());
            err_other++;
        end
    endtask

    task automatic reset_values();
        int cycles;
        expect_flag(s_hdr_ready, 1'b0, "s_hdr_ready in reset");
        expect_flag(s_payload_ready, 1'b0, "s_payload_ready in reset");
        expect_flag(m_meta_valid, 1'b0, "m_meta_valid in reset");
        expect_flag(m_payload_valid, 1'b0, "m_payload_valid in reset");
        expect_flag(busy, 1'b0, "busy in reset");
        cycles = 0;
        while (!s_hdr_ready && cycles < wait_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!s_hdr_ready) begin
            $display("s_hdr_ready never rose after reset");
            err_other++;
        end
        expect_flag(m_meta_valid, 1'b0, "m_meta_valid after reset");
        expect_flag(m_payload_valid, 1'b0, "m_payload_valid after reset");
        expect_flag(busy, 1'b0, "busy after reset");
    endtask

    task automatic single_beat_frame();
        icmp_hdr_t hdr;
        make_frame(1, 8, hdr);
        send_frame(hdr);
        wait_drained("single-beat frame");
    endtask

    task automatic odd_length_frame();
        icmp_hdr_t hdr;
        make_frame(3, 5, hdr);
        send_frame(hdr);
        wait_drained("odd-length frame");
    endtask

    task automatic one_byte_frame();
        icmp_hdr_t hdr;
        make_frame(1, 1, hdr);
        send_frame(hdr);
        wait_drained("one-byte frame");
    endtask

    task automatic stalled_outputs();
        icmp_hdr_t hdr;
        int        f;
        @(posedge clk);
        m_payload_ready <= 1'b0;
        m_meta_ready <= 1'b0;
        for (f = 0; f < 3; f++) begin
            make_frame(f + 3, 2 * f + 3, hdr);
            send_frame(hdr);
        end
        repeat (20) @(posedge clk);
        expect_flag(m_meta_valid, 1'b1, "m_meta_valid while stalled");
        expect_flag(m_payload_valid, 1'b1, "m_payload_valid while stalled");
        m_payload_ready <= 1'b1;
        m_meta_ready <= 1'b1;
        wait_drained("stalled frames");
    endtask

    task automatic random_frames();
        icmp_hdr_t hdr;
        int        f;
        int        nbeats;
        int        last_bytes;
        for (f = 0; f < 8; f++) begin
            nbeats = 1 + $unsigned($random(seed)) % 12;
            last_bytes = 1 + $unsigned($random(seed)) % 8;
            make_frame(nbeats, last_bytes, hdr);
            send_frame(hdr);
            wait_drained("random frame");
            expect_flag(busy, 1'b0, "busy after random frame");
        end
    endtask

    initial begin
        seed = 90956;
        err_value = 0;
        err_other = 0;
        rst <= 1'b1;
        s_hdr <= '0;
        s_hdr_valid <= 1'b0;
        s_payload <= '0;
        s_payload_valid <= 1'b0;
        m_meta_ready <= 1'b1;
        m_payload_ready <= 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        reset_values();
        single_beat_frame();
        odd_length_frame();
        one_byte_frame();
        stalled_outputs();
        random_frames();

        $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+sim
design/icmp_pkg.sv
design/sync_fifo.sv
design/icmp_beat_sum.sv
design/icmp_csum_ctrl.sv
design/icmp_checksum_gen.sv
sim/tb_icmp_checksum_gen.sv
